// ==== source/l2_cache_config.svh ====
`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

// ==================================================
// Cache geometry
// ==================================================

// Index bits select one of 2**N single-word lines.
`define L2_INDEX_BITS 8

// Bus and CPU widths.
`define L2_ADDR_BITS 32
`define L2_DATA_BITS 32

// Tag is what is left above the index and the two byte bits.
`define L2_TAG_BITS (`L2_ADDR_BITS - `L2_INDEX_BITS - 2)

`endif

// ==== source/l2_cache_pkg.sv ====
`include "l2_cache_config.svh"

package l2_cache_pkg;

	// Byte address, the two low bits are ignored.
	typedef logic [`L2_ADDR_BITS-1:0] addr_t;

	// One data word, which is also one cache line.
	typedef logic [`L2_DATA_BITS-1:0] data_t;

	// Line index, taken from the address just above the byte bits.
	typedef logic [`L2_INDEX_BITS-1:0] index_t;

	// Tag, taken from the upper address bits.
	typedef logic [`L2_TAG_BITS-1:0] tag_t;

	// Controller states.
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		EVICT,
		REFILL,
		THROUGH,
		DONE
	} ctrl_state_t;

endpackage

// ==== source/l2_line_store.sv ====
`timescale 1ns/1ps
`include "l2_cache_config.svh"

module l2_line_store
	import l2_cache_pkg::*;
(
	input  logic   i_clock,
	input  logic   i_rst_n,
	input  index_t i_index,
	input  logic   i_write,
	input  logic   i_valid,
	input  logic   i_dirty,
	input  tag_t   i_tag,
	input  data_t  i_data,
	output logic   o_valid,
	output logic   o_dirty,
	output tag_t   o_tag,
	output data_t  o_data,
	output logic   o_initialized
);

	localparam int LINES = 1 << `L2_INDEX_BITS;

	logic  mem_valid [0:LINES-1];
	logic  mem_dirty [0:LINES-1];
	tag_t  mem_tag   [0:LINES-1];
	data_t mem_data  [0:LINES-1];

	index_t sweep_index;

	// Write port, owned by the sweep until it has covered every line.
	logic   wr_en;
	index_t wr_index;
	logic   wr_valid;
	logic   wr_dirty;
	tag_t   wr_tag;
	data_t  wr_data;

	assign wr_en    = o_initialized ? i_write : 1'b1;
	assign wr_index = o_initialized ? i_index : sweep_index;
	assign wr_valid = o_initialized ? i_valid : 1'b0;
	assign wr_dirty = o_initialized ? i_dirty : 1'b0;
	assign wr_tag   = o_initialized ? i_tag : '0;
	assign wr_data  = o_initialized ? i_data : '0;

	// Sweep counter, one entry per cycle after reset.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sweep_index   <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			sweep_index <= sweep_index + 1'b1;
			if (sweep_index == index_t'(LINES - 1))
				o_initialized <= 1'b1;
		end
	end

	// Memory write and registered read.
	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			mem_valid[wr_index] <= wr_valid;
			mem_dirty[wr_index] <= wr_dirty;
			mem_tag[wr_index]   <= wr_tag;
			mem_data[wr_index]  <= wr_data;
		end
		o_valid <= mem_valid[i_index];
		o_dirty <= mem_dirty[i_index];
		o_tag   <= mem_tag[i_index];
		o_data  <= mem_data[i_index];
	end

	// The controller only installs lines once the sweep is over.
	a_no_write_before_init: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		i_write |-> o_initialized
	);

endmodule

// ==== source/l2_bus_master.sv ====
`timescale 1ns/1ps

module l2_bus_master
	import l2_cache_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_rst_n,

	// Controller side.
	input  logic  i_start,
	input  logic  i_rw,
	input  addr_t i_address,
	input  data_t i_wdata,
	output logic  o_done,
	output data_t o_rdata,

	// Bus side.
	output logic  o_bus_request,
	output logic  o_bus_rw,
	output addr_t o_bus_address,
	output data_t o_bus_wdata,
	input  logic  i_bus_ready,
	input  data_t i_bus_rdata
);

	logic bus_accept;

	// The bus answers while a request is open.
	assign bus_accept = o_bus_request && i_bus_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_request <= 1'b0;
			o_done        <= 1'b0;
		end else begin
			o_done <= bus_accept;
			if (i_start)
				o_bus_request <= 1'b1;
			else if (bus_accept)
				o_bus_request <= 1'b0;
		end
	end

	// Transaction payload, held until the bus answers.
	always_ff @(posedge i_clock) begin
		if (i_start) begin
			o_bus_rw      <= i_rw;
			o_bus_address <= i_address;
			o_bus_wdata   <= i_wdata;
		end
		if (bus_accept)
			o_rdata <= i_bus_rdata;
	end

	// Held bus address under back-pressure.
	a_addr_stable: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address))
	);

	// One transaction at a time.
	a_no_start_when_busy: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		i_start |-> !o_bus_request
	);

endmodule

// ==== source/l2_cache_control.sv ====
`timescale 1ns/1ps
`include "l2_cache_config.svh"

module l2_cache_control
	import l2_cache_pkg::*;
(
	input  logic   i_clock,
	input  logic   i_rst_n,

	// CPU side.
	input  logic   i_request,
	input  logic   i_rw,
	input  addr_t  i_address,
	input  data_t  i_wdata,
	output logic   o_ready,
	output data_t  o_rdata,

	// Line store.
	output index_t o_st_index,
	output logic   o_st_write,
	output logic   o_st_valid,
	output logic   o_st_dirty,
	output tag_t   o_st_tag,
	output data_t  o_st_data,
	input  logic   i_st_valid,
	input  logic   i_st_dirty,
	input  tag_t   i_st_tag,
	input  data_t  i_st_data,
	input  logic   i_st_initialized,

	// Bus master.
	output logic   o_bm_start,
	output logic   o_bm_rw,
	output addr_t  o_bm_address,
	output data_t  o_bm_wdata,
	input  logic   i_bm_done,
	input  data_t  i_bm_rdata
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	index_t req_index;
	tag_t   req_tag;
	logic   hit;
	logic   victim_dirty;
	addr_t  victim_address;

	// ==================================================
	// Address split and hit check
	// ==================================================

	assign req_index = i_address[`L2_INDEX_BITS+1:2];
	assign req_tag   = i_address[`L2_ADDR_BITS-1:`L2_INDEX_BITS+2];

	// Request fields are held so the store keeps returning this line.
	assign o_st_index = req_index;

	assign hit            = i_st_valid && (i_st_tag == req_tag);
	assign victim_dirty   = i_st_valid && i_st_dirty && !hit;
	assign victim_address = {i_st_tag, req_index, 2'b00};

	// Store data in LOOKUP and bus data after any bus transaction.
	assign o_rdata = (state == LOOKUP) ? i_st_data : i_bm_rdata;

	// ==================================================
	// State register
	// ==================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	// ==================================================
	// Next state and outputs
	// ==================================================

	always_comb begin
		next_state   = state;
		o_ready      = 1'b0;
		o_st_write   = 1'b0;
		o_st_valid   = 1'b1;
		o_st_dirty   = 1'b1;
		o_st_tag     = req_tag;
		o_st_data    = i_wdata;
		o_bm_start   = 1'b0;
		o_bm_rw      = i_rw;
		o_bm_address = i_address;
		o_bm_wdata   = i_wdata;

		case (state)
			IDLE: begin
				if (i_request) begin
					if (i_st_initialized) begin
						next_state = LOOKUP;
					end else begin
						// The store is still sweeping. Go straight to the bus.
						o_bm_start = 1'b1;
						next_state = THROUGH;
					end
				end
			end

			LOOKUP: begin
				if (!i_rw && hit) begin
					o_ready    = 1'b1;
					next_state = DONE;
				end else if (i_rw && !victim_dirty) begin
					// Matching or clean entry takes the write.
					o_st_write = 1'b1;
					o_ready    = 1'b1;
					next_state = DONE;
				end else if (victim_dirty) begin
					o_bm_start   = 1'b1;
					o_bm_rw      = 1'b1;
					o_bm_address = victim_address;
					o_bm_wdata   = i_st_data;
					next_state   = EVICT;
				end else begin
					o_bm_start = 1'b1;
					o_bm_rw    = 1'b0;
					next_state = REFILL;
				end
			end

			EVICT: begin
				if (i_bm_done) begin
					if (i_rw) begin
						o_st_write = 1'b1;
						o_ready    = 1'b1;
						next_state = DONE;
					end else begin
						// Old word is out. Now fetch the missing one.
						o_bm_start = 1'b1;
						o_bm_rw    = 1'b0;
						next_state = REFILL;
					end
				end
			end

			REFILL: begin
				if (i_bm_done) begin
					o_st_write = 1'b1;
					o_st_dirty = 1'b0;
					o_st_data  = i_bm_rdata;
					o_ready    = 1'b1;
					next_state = DONE;
				end
			end

			THROUGH: begin
				if (i_bm_done) begin
					o_ready    = 1'b1;
					next_state = DONE;
				end
			end

			DONE: begin
				if (!i_request)
					next_state = IDLE;
			end

			default: next_state = IDLE;
		endcase
	end

	// The CPU answer never overlaps a new bus transaction.
	a_ready_not_start: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		!(o_ready && o_bm_start)
	);

endmodule

// ==== source/l2_cache_top.sv ====
`timescale 1ns/1ps

module l2_cache_top
	import l2_cache_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_rst_n,

	// CPU side.
	input  logic  i_request,
	input  logic  i_rw,
	input  addr_t i_address,
	input  data_t i_wdata,
	output logic  o_ready,
	output data_t o_rdata,

	// Backing bus.
	output logic  o_bus_request,
	output logic  o_bus_rw,
	output addr_t o_bus_address,
	output data_t o_bus_wdata,
	input  logic  i_bus_ready,
	input  data_t i_bus_rdata
);

	// Controller to store.
	index_t st_index;
	logic   st_write;
	logic   st_valid;
	logic   st_dirty;
	tag_t   st_tag;
	data_t  st_data;
	logic   st_q_valid;
	logic   st_q_dirty;
	tag_t   st_q_tag;
	data_t  st_q_data;
	logic   st_initialized;

	// Controller to bus master.
	logic   bm_start;
	logic   bm_rw;
	addr_t  bm_address;
	data_t  bm_wdata;
	logic   bm_done;
	data_t  bm_rdata;

	l2_cache_control u_control (
		.i_clock          (i_clock),
		.i_rst_n          (i_rst_n),
		.i_request        (i_request),
		.i_rw             (i_rw),
		.i_address        (i_address),
		.i_wdata          (i_wdata),
		.o_ready          (o_ready),
		.o_rdata          (o_rdata),
		.o_st_index       (st_index),
		.o_st_write       (st_write),
		.o_st_valid       (st_valid),
		.o_st_dirty       (st_dirty),
		.o_st_tag         (st_tag),
		.o_st_data        (st_data),
		.i_st_valid       (st_q_valid),
		.i_st_dirty       (st_q_dirty),
		.i_st_tag         (st_q_tag),
		.i_st_data        (st_q_data),
		.i_st_initialized (st_initialized),
		.o_bm_start       (bm_start),
		.o_bm_rw          (bm_rw),
		.o_bm_address     (bm_address),
		.o_bm_wdata       (bm_wdata),
		.i_bm_done        (bm_done),
		.i_bm_rdata       (bm_rdata)
	);

	l2_line_store u_store (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_index       (st_index),
		.i_write       (st_write),
		.i_valid       (st_valid),
		.i_dirty       (st_dirty),
		.i_tag         (st_tag),
		.i_data        (st_data),
		.o_valid       (st_q_valid),
		.o_dirty       (st_q_dirty),
		.o_tag         (st_q_tag),
		.o_data        (st_q_data),
		.o_initialized (st_initialized)
	);

	l2_bus_master u_bus_master (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_start       (bm_start),
		.i_rw          (bm_rw),
		.i_address     (bm_address),
		.i_wdata       (bm_wdata),
		.o_done        (bm_done),
		.o_rdata       (bm_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

// ==== verification/l2_mem_model.sv ====
`timescale 1ns/1ps

module l2_mem_model
	import l2_cache_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_rst_n,
	input  logic  i_bus_request,
	input  logic  i_bus_rw,
	input  addr_t i_bus_address,
	input  data_t i_bus_wdata,
	output logic  o_bus_ready,
	output data_t o_bus_rdata
);

	localparam int MODEL_WORDS = 4096;

	data_t mem     [0:MODEL_WORDS-1];
	logic  written [0:MODEL_WORDS-1];

	logic        busy;
	logic [1:0]  wait_count;
	logic [31:0] rng_state;
	logic [31:0] rng_next;

	// Bus activity seen so far.
	int    read_count;
	int    write_count;
	addr_t last_read_address;
	addr_t last_write_address;
	data_t last_write_data;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Untouched words follow a pattern of the full address.
	function automatic data_t fill_word(input addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
	endfunction

	function automatic data_t peek(input addr_t a);
		if (written[a[13:2]])
			return mem[a[13:2]];
		return fill_word(a);
	endfunction

	initial begin
		for (int i = 0; i < MODEL_WORDS; i++)
			written[i] = 1'b0;
	end

	assign rng_next = xorshift32(rng_state);

	// Answer each request after one to four cycles.
	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_ready        <= 1'b0;
			o_bus_rdata        <= '0;
			busy               <= 1'b0;
			wait_count         <= '0;
			rng_state          <= 32'd66;
			read_count         <= 0;
			write_count        <= 0;
			last_read_address  <= '0;
			last_write_address <= '0;
			last_write_data    <= '0;
		end else begin
			o_bus_ready <= 1'b0;
			if (o_bus_ready) begin
				// Request drops on this edge.
			end else if (!busy && i_bus_request) begin
				busy       <= 1'b1;
				wait_count <= rng_next[1:0];
				rng_state  <= rng_next;
			end else if (busy) begin
				if (wait_count == 0) begin
					busy        <= 1'b0;
					o_bus_ready <= 1'b1;
					if (i_bus_rw) begin
						mem[i_bus_address[13:2]]     <= i_bus_wdata;
						written[i_bus_address[13:2]] <= 1'b1;
						write_count                  <= write_count + 1;
						last_write_address           <= i_bus_address;
						last_write_data              <= i_bus_wdata;
					end else begin
						o_bus_rdata       <= peek(i_bus_address);
						read_count        <= read_count + 1;
						last_read_address <= i_bus_address;
					end
				end else begin
					wait_count <= wait_count - 1'b1;
				end
			end
		end
	end

endmodule

// ==== verification/l2_cache_tb.sv ====
`timescale 1ns/1ps
`include "l2_cache_config.svh"

module l2_cache_tb
	import l2_cache_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 256 + 300 * 20;
	localparam int ACCESS_LIMIT   = 100;
	localparam int SLOTS          = 32;

	logic  clock;
	logic  rst_n;
	logic  request;
	logic  rw;
	addr_t address;
	data_t wdata;
	logic  ready;
	data_t rdata;
	logic  bus_request;
	logic  bus_rw;
	addr_t bus_address;
	data_t bus_wdata;
	logic  bus_ready;
	data_t bus_rdata;

	int          mismatch_count = 0;
	int          failure_count  = 0;
	int          cycle_count    = 0;
	logic [31:0] rng_state;
	data_t       ref_mem [0:SLOTS-1];

	l2_cache_top uut (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_request     (request),
		.i_rw          (rw),
		.i_address     (address),
		.i_wdata       (wdata),
		.o_ready       (ready),
		.o_rdata       (rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	l2_mem_model u_mem (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ==================================================
	// Helpers and compare tasks
	// ==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Four tags over eight lines.
	function automatic addr_t slot_addr(input int slot);
		return 32'h0000_2000 + (addr_t'(slot / 8) << (`L2_INDEX_BITS + 2))
			+ (addr_t'(slot % 8) << 2);
	endfunction

	task automatic check_data(input data_t got, input data_t exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string msg);
		if (got != exp) begin
			$display("mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
			mismatch_count++;
		end
	endtask

	// Runs one CPU access and counts rising edges up to the one that sees ready.
	task automatic run_access(input logic op_rw, input addr_t addr, input data_t data,
			output data_t result, output int edges);
		logic seen;
		seen   = 1'b0;
		edges  = 0;
		result = '0;
		@(posedge clock);
		#1;
		request = 1'b1;
		rw      = op_rw;
		address = addr;
		wdata   = data;
		while (!seen && edges < ACCESS_LIMIT) begin
			@(negedge clock);
			seen = ready;
			if (ready)
				result = rdata;
			@(posedge clock);
			edges++;
		end
		if (!seen) begin
			$display("Access to address %h never got ready after %0d cycles", addr, edges);
			failure_count++;
		end
		#1;
		request = 1'b0;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_pass_through();
		data_t r;
		int    e;
		int    reads;
		int    writes;
		reads  = u_mem.read_count;
		writes = u_mem.write_count;
		run_access(1'b1, 32'h0000_0040, 32'h1234_5678, r, e);
		check_count(u_mem.write_count, writes + 1, "pass-through bus writes");
		check_addr(u_mem.last_write_address, 32'h0000_0040, "pass-through write address");
		check_data(u_mem.last_write_data, 32'h1234_5678, "pass-through write data");
		run_access(1'b0, 32'h0000_0040, '0, r, e);
		check_count(u_mem.read_count, reads + 1, "pass-through bus reads");
		check_data(r, u_mem.peek(32'h0000_0040), "pass-through read data");
		check_count(int'(uut.st_initialized), 0, "store still sweeping");
	endtask

	task automatic test_write_read_hit();
		data_t r;
		int    e;
		int    reads;
		int    writes;
		while (!uut.st_initialized)
			@(posedge clock);
		reads  = u_mem.read_count;
		writes = u_mem.write_count;
		run_access(1'b1, 32'h0000_0080, 32'hCAFE_0001, r, e);
		check_count(e, 2, "write latency");
		run_access(1'b0, 32'h0000_0080, '0, r, e);
		check_count(e, 2, "read hit latency");
		check_data(r, 32'hCAFE_0001, "read hit data");
		check_count(u_mem.read_count, reads, "bus reads on hit");
		check_count(u_mem.write_count, writes, "bus writes on hit");
	endtask

	task automatic test_clean_miss();
		data_t r;
		int    e;
		int    reads;
		reads = u_mem.read_count;
		run_access(1'b0, 32'h0000_00C0, '0, r, e);
		check_count(u_mem.read_count, reads + 1, "clean miss bus reads");
		check_addr(u_mem.last_read_address, 32'h0000_00C0, "clean miss read address");
		check_data(r, u_mem.peek(32'h0000_00C0), "clean miss data");
	endtask

	task automatic test_dirty_evict();
		data_t r;
		int    e;
		int    reads;
		int    writes;
		run_access(1'b1, 32'h0000_0100, 32'hAAAA_0100, r, e);
		writes = u_mem.write_count;
		run_access(1'b1, 32'h0000_0500, 32'hBBBB_0500, r, e);
		check_count(u_mem.write_count, writes + 1, "eviction bus writes");
		check_addr(u_mem.last_write_address, 32'h0000_0100, "eviction address");
		check_data(u_mem.last_write_data, 32'hAAAA_0100, "eviction data");
		reads = u_mem.read_count;
		run_access(1'b0, 32'h0000_0100, '0, r, e);
		check_count(u_mem.read_count, reads + 1, "refill bus reads");
		check_addr(u_mem.last_read_address, 32'h0000_0100, "refill address");
		check_data(r, 32'hAAAA_0100, "refill data");
	endtask

	task automatic test_random_sequence();
		data_t  r;
		data_t  d;
		int     e;
		int     slot;
		logic   op_rw;
		addr_t  a;
		index_t idx;
		tag_t   tag;
		logic   cached_dirty;
		for (int i = 0; i < SLOTS; i++)
			ref_mem[i] = u_mem.peek(slot_addr(i));
		for (int n = 0; n < 200; n++) begin
			rng_state = xorshift32(rng_state);
			slot      = int'(rng_state[4:0]);
			op_rw     = rng_state[8];
			rng_state = xorshift32(rng_state);
			d         = rng_state;
			run_access(op_rw, slot_addr(slot), d, r, e);
			if (op_rw)
				ref_mem[slot] = d;
			else
				check_data(r, ref_mem[slot], "random read");
		end
		// Clean or absent lines must already be in the model.
		for (int i = 0; i < SLOTS; i++) begin
			a   = slot_addr(i);
			idx = a[`L2_INDEX_BITS+1:2];
			tag = a[`L2_ADDR_BITS-1:`L2_INDEX_BITS+2];
			cached_dirty = uut.u_store.mem_valid[idx] && uut.u_store.mem_dirty[idx]
				&& (uut.u_store.mem_tag[idx] == tag);
			if (!cached_dirty)
				check_data(u_mem.peek(a), ref_mem[i], "model word after random run");
		end
		for (int i = 0; i < SLOTS; i++) begin
			run_access(1'b0, slot_addr(i), '0, r, e);
			check_data(r, ref_mem[i], "read back after random run");
		end
	endtask

	initial begin
		clock     = 1'b0;
		rst_n     = 1'b0;
		request   = 1'b0;
		rw        = 1'b0;
		address   = '0;
		wdata     = '0;
		rng_state = 32'd66;
		repeat (16) @(posedge clock);
		#1;
		rst_n = 1'b1;

		test_pass_through();
		test_write_read_hit();
		test_clean_miss();
		test_dirty_evict();
		test_random_sequence();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+source
source/l2_cache_pkg.sv
source/l2_line_store.sv
source/l2_bus_master.sv
source/l2_cache_control.sv
source/l2_cache_top.sv
verification/l2_mem_model.sv
verification/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - include_dirs:
      - source
    files:
      - source/l2_cache_pkg.sv
      - source/l2_line_store.sv
      - source/l2_bus_master.sv
      - source/l2_cache_control.sv
      - source/l2_cache_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/l2_mem_model.sv
      - verification/l2_cache_tb.sv
